// File: common/cmd_pkg.sv
package cmd_pkg;

    localparam int addr_bits   = 13; // register command address width
    localparam int data_bits   = 32; // register command data width
    localparam int len_low_bit = 4;  // address[len_low_bit+:4] selects the command length

    // command length in cycles, indexed by address[7:4]
    localparam logic [3:0] len_table [16] = '{
        4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, // codes 0..5
        4'd6, 4'd6, 4'd6, 4'd6, 4'd6,       // codes 6..10
        4'd6, 4'd6, 4'd6, 4'd6, 4'd6        // codes 11..15
    };

    localparam logic [addr_bits-1:0] ctrl_addr = 13'h1000; // control register window
    localparam logic [addr_bits-1:0] ctrl_mask = 13'h1400; // bits compared against ctrl_addr

    typedef enum logic {
        idle,  // no byte stream in progress
        shift  // byte stream of the current command still running
    } mux_state_e;

    typedef enum logic {
        load,  // host fills the command store
        play   // store is replayed after frame_sync
    } seq_state_e;

    // byte position inside the serial stream
    typedef enum logic [2:0] {
        al, ah, d0, d1, d2, d3
    } slv_state_e;

endpackage

// File: design/cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo #(
    parameter int fifo_depth = 4 // entries, busy threshold is half of it
) (
    input  logic                          rst,          // clock
    input  logic                          mclk,         // async reset, active high
    input  logic [cmd_pkg::addr_bits-1:0] pre_waddr,    // burst address, valid with start_wburst
    input  logic                          start_wburst, // first cycle of a host burst
    input  logic [cmd_pkg::addr_bits-1:0] waddr,        // write address, valid with wr_en
    input  logic                          wr_en,        // host write strobe
    input  logic [cmd_pkg::data_bits-1:0] wdata,        // write data, valid with wr_en
    input  logic                          fifo_re,      // pop head entry
    output logic                          busy,         // host must hold off writes
    output logic                          fifo_nempty,  // at least one entry stored
    output logic [cmd_pkg::addr_bits-1:0] fifo_addr,    // head address
    output logic [cmd_pkg::data_bits-1:0] fifo_data     // head data
);
    localparam int pw = $clog2(fifo_depth);     // pointer width
    localparam int cw = $clog2(fifo_depth + 1); // entry count width

    logic [cmd_pkg::addr_bits-1:0] mem_a [fifo_depth]; // address storage
    logic [cmd_pkg::data_bits-1:0] mem_d [fifo_depth]; // data storage
    logic [pw-1:0] wp, rp;    // write and read pointers
    logic [cw-1:0] count;     // entries held
    logic          selected;  // current burst targets the control range
    logic          selected_w; // filter result for pre_waddr
    logic          push, pop;

    assign selected_w = ((pre_waddr ^ cmd_pkg::ctrl_addr) & cmd_pkg::ctrl_mask) == '0;
    // fresh decode during start_wburst, stored one for the rest of the burst
    assign busy = (count >= cw'(fifo_depth / 2)) && (start_wburst ? selected_w : selected);

    assign push = wr_en && selected && (count != cw'(fifo_depth)); // write to a full FIFO is lost
    assign pop  = fifo_re && (count != '0);

    assign fifo_nempty = count != '0;
    assign fifo_addr   = mem_a[rp];
    assign fifo_data   = mem_d[rp];

    always_ff @(posedge rst) begin
        if (push) begin
            mem_a[wp] <= waddr;
            mem_d[wp] <= wdata;
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            selected <= 1'b0;
            wp       <= '0;
            rp       <= '0;
            count    <= '0;
        end else begin
            if (start_wburst) selected <= selected_w; // held for the whole burst
            if (push) wp <= (wp == pw'(fifo_depth - 1)) ? '0 : wp + 1'b1;
            if (pop)  rp <= (rp == pw'(fifo_depth - 1)) ? '0 : rp + 1'b1;
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

endmodule

// File: design/cmd_seq.sv
`timescale 1ns/10ps

module cmd_seq #(
    parameter int seq_depth = 8 // commands held in the store
) (
    input  logic                          rst,        // clock
    input  logic                          mclk,       // async reset, active high
    input  logic                          seq_we,     // append one command
    input  logic [cmd_pkg::addr_bits-1:0] seq_waddr,  // appended command address
    input  logic [cmd_pkg::data_bits-1:0] seq_wdata,  // appended command data
    input  logic                          seq_clr,    // empty the store
    input  logic                          frame_sync, // start of frame, triggers replay
    input  logic                          cseq_ackn,  // mux took the presented command
    output logic                          cseq_wr_en, // command presented
    output logic [cmd_pkg::addr_bits-1:0] cseq_waddr, // presented address
    output logic [cmd_pkg::data_bits-1:0] cseq_wdata  // presented data
);
    localparam int pw = $clog2(seq_depth);     // replay pointer width
    localparam int cw = $clog2(seq_depth + 1); // fill count width

    cmd_pkg::seq_state_e state;
    logic [cmd_pkg::addr_bits-1:0] mem_a [seq_depth]; // stored addresses
    logic [cmd_pkg::data_bits-1:0] mem_d [seq_depth]; // stored data
    logic [cw-1:0] fill;  // commands in the store
    logic [pw-1:0] rp;    // replay pointer
    logic          wr_ok; // append accepted
    logic          take;  // presented command accepted by the mux

    assign wr_ok = seq_we && !seq_clr && (fill != cw'(seq_depth));
    assign take  = cseq_wr_en && cseq_ackn;

    assign cseq_wr_en = state == cmd_pkg::play; // registered, so one cycle after frame_sync
    assign cseq_waddr = mem_a[rp];
    assign cseq_wdata = mem_d[rp];

    always_ff @(posedge rst) begin
        if (wr_ok) begin
            mem_a[pw'(fill)] <= seq_waddr;
            mem_d[pw'(fill)] <= seq_wdata;
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state <= cmd_pkg::load;
            fill  <= '0;
            rp    <= '0;
        end else begin
            if (seq_clr)    fill <= '0;
            else if (wr_ok) fill <= fill + 1'b1;

            if (seq_clr) begin
                state <= cmd_pkg::load; // stop any replay in progress
            end else if (state == cmd_pkg::load) begin
                if (frame_sync && fill != '0) begin // empty store stays in load
                    state <= cmd_pkg::play;
                    rp    <= '0;
                end
            end else if (take) begin // frame_sync while playing is ignored
                rp <= rp + 1'b1;
                if (cw'(rp) == fill - 1'b1) state <= cmd_pkg::load; // last one taken
            end
        end
    end

endmodule

// File: cmd_mux/cmd_mux.sv
`timescale 1ns/10ps

module cmd_mux (
    input  logic                          rst,         // clock
    input  logic                          mclk,        // async reset, active high
    input  logic                          fifo_nempty, // host FIFO has a command
    input  logic [cmd_pkg::addr_bits-1:0] fifo_addr,   // FIFO head address
    input  logic [cmd_pkg::data_bits-1:0] fifo_data,   // FIFO head data
    input  logic                          cseq_wr_en,  // sequencer presents a command
    input  logic [cmd_pkg::addr_bits-1:0] cseq_waddr,  // sequencer address
    input  logic [cmd_pkg::data_bits-1:0] cseq_wdata,  // sequencer data
    output logic                          fifo_re,     // pop FIFO head
    output logic                          cseq_ackn,   // sequencer command taken
    output logic [cmd_pkg::addr_bits-1:0] par_waddr,   // parallel address
    output logic [cmd_pkg::data_bits-1:0] par_data,    // parallel data
    output logic [7:0]                    byte_ad,     // serial stream AL AH D0 D1 D2 D3
    output logic                          ad_stb       // first cycle of a command
);
    localparam int sr_bits = cmd_pkg::data_bits + 16; // data plus two address bytes

    cmd_pkg::mux_state_e state;
    logic [2:0]         cnt;        // cycles left in the current stream
    logic [3:0]         len_w;      // length of the command just strobed
    logic               can_start;  // previous stream ends this cycle
    logic               start_w;    // launch a command now
    logic               seq_full;   // holding register has a sequencer command
    logic [sr_bits-1:0] sr;         // byte shifter
    logic [cmd_pkg::addr_bits-1:0] seq_addr_r; // held sequencer address
    logic [cmd_pkg::data_bits-1:0] seq_data_r; // held sequencer data
    logic [cmd_pkg::addr_bits-1:0] cmd_addr;   // selected source address
    logic [cmd_pkg::data_bits-1:0] cmd_data;   // selected source data

    // sr is not shifted yet during ad_stb, so the length field is intact
    assign len_w = cmd_pkg::len_table[sr[cmd_pkg::len_low_bit +: 4]];

    assign can_start = ad_stb ? (len_w == 4'd1) : (state == cmd_pkg::idle || cnt == 3'd1);
    assign start_w   = can_start && (seq_full || fifo_nempty);
    assign fifo_re   = can_start && !seq_full && fifo_nempty; // sequencer wins
    // register may refill while its command is being started
    assign cseq_ackn = cseq_wr_en && (!seq_full || can_start);

    assign cmd_addr = seq_full ? seq_addr_r : fifo_addr;
    assign cmd_data = seq_full ? seq_data_r : fifo_data;
    assign byte_ad  = sr[7:0];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            ad_stb   <= 1'b0;
            seq_full <= 1'b0;
            state    <= cmd_pkg::idle;
            cnt      <= '0;
        end else begin
            ad_stb   <= start_w;
            seq_full <= cseq_ackn || (seq_full && !can_start);
            if (ad_stb) begin
                state <= (len_w == 4'd1) ? cmd_pkg::idle : cmd_pkg::shift;
                cnt   <= 3'(len_w - 4'd1);
            end else if (state == cmd_pkg::shift) begin
                cnt <= cnt - 1'b1;
                if (cnt == 3'd1) state <= cmd_pkg::idle; // last byte on the bus
            end
        end
    end

    always_ff @(posedge rst) begin
        if (cseq_ackn) begin
            seq_addr_r <= cseq_waddr;
            seq_data_r <= cseq_wdata;
        end
        if (start_w) begin
            par_waddr <= cmd_addr; // held until the next start
            par_data  <= cmd_data;
            sr        <= {cmd_data, {(16 - cmd_pkg::addr_bits){1'b0}}, cmd_addr};
        end else begin
            sr <= {8'h00, sr[sr_bits-1:8]}; // next byte to byte_ad
        end
    end

endmodule

// File: design/byte_slave.sv
`timescale 1ns/10ps

module byte_slave #(
    parameter logic [4:0] slave_base = 5'h10 // address[12:8] owned by this slave
) (
    input  logic                          rst,     // clock
    input  logic                          mclk,    // async reset, active high
    input  logic                          ad_stb,  // AL on byte_ad
    input  logic [7:0]                    byte_ad, // serial command bytes
    input  logic [3:0]                    rd_addr, // register read index
    output logic [cmd_pkg::data_bits-1:0] rd_data, // register read data
    output logic                          wr_done  // command stored
);
    cmd_pkg::slv_state_e pos; // byte expected next, al when idle
    logic [3:0]  len_r;   // length of the command in progress
    logic [3:0]  len_w;   // length taken from AL
    logic        last_w;  // final byte of the command arrives now
    logic [47:0] asm;     // bytes collected so far
    logic [47:0] asm_w;   // collected bytes including the current one
    logic [cmd_pkg::data_bits-1:0] regs [16]; // register file

    assign len_w   = cmd_pkg::len_table[byte_ad[7:4]];
    assign rd_data = regs[rd_addr];
    assign last_w  = ad_stb ? (len_w == 4'd1)
                            : (pos != cmd_pkg::al && int'(pos) + 1 == int'(len_r));

    always_comb begin
        asm_w = asm;
        if (ad_stb) asm_w = {40'h0, byte_ad}; // unsent bytes stay zero
        else        asm_w[8 * int'(pos) +: 8] = byte_ad;
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            pos     <= cmd_pkg::al;
            wr_done <= 1'b0;
        end else begin
            wr_done <= last_w;
            if (ad_stb)
                pos <= (len_w == 4'd1) ? cmd_pkg::al : cmd_pkg::ah;
            else if (pos != cmd_pkg::al)
                pos <= last_w ? cmd_pkg::al : cmd_pkg::slv_state_e'(int'(pos) + 1);
        end
    end

    always_ff @(posedge rst) begin
        asm <= asm_w;
        if (ad_stb) len_r <= len_w;
        // stored together with wr_done, so rd_data is current once it pulses
        if (last_w && asm_w[12:8] == slave_base)
            regs[asm_w[3:0]] <= asm_w[47:16];
    end

endmodule

// File: design/cmd_top.sv
`timescale 1ns/10ps

module cmd_top #(
    parameter int         fifo_depth = 4,    // host FIFO entries
    parameter int         seq_depth  = 8,    // sequencer store size
    parameter logic [4:0] slave_base = 5'h10 // byte slave address[12:8]
) (
    input  logic                          rst,          // clock
    input  logic                          mclk,         // async reset, active high
    input  logic [cmd_pkg::addr_bits-1:0] pre_waddr,
    input  logic                          start_wburst,
    input  logic [cmd_pkg::addr_bits-1:0] waddr,
    input  logic                          wr_en,
    input  logic [cmd_pkg::data_bits-1:0] wdata,
    output logic                          busy,
    input  logic                          seq_we,
    input  logic [cmd_pkg::addr_bits-1:0] seq_waddr,
    input  logic [cmd_pkg::data_bits-1:0] seq_wdata,
    input  logic                          seq_clr,
    input  logic                          frame_sync,
    output logic [cmd_pkg::addr_bits-1:0] par_waddr,
    output logic [cmd_pkg::data_bits-1:0] par_data,
    output logic [7:0]                    byte_ad,
    output logic                          ad_stb,
    input  logic [3:0]                    rd_addr,
    output logic [cmd_pkg::data_bits-1:0] rd_data,
    output logic                          wr_done
);
    logic                          fifo_nempty, fifo_re;
    logic [cmd_pkg::addr_bits-1:0] fifo_addr;
    logic [cmd_pkg::data_bits-1:0] fifo_data;
    logic                          cseq_wr_en, cseq_ackn;
    logic [cmd_pkg::addr_bits-1:0] cseq_waddr;
    logic [cmd_pkg::data_bits-1:0] cseq_wdata;

    cmd_fifo #(.fifo_depth(fifo_depth)) cmd_fifo_i (
        .rst(rst), .mclk(mclk),
        .pre_waddr(pre_waddr), .start_wburst(start_wburst),
        .waddr(waddr), .wr_en(wr_en), .wdata(wdata),
        .fifo_re(fifo_re), .busy(busy),
        .fifo_nempty(fifo_nempty), .fifo_addr(fifo_addr), .fifo_data(fifo_data)
    );

    cmd_seq #(.seq_depth(seq_depth)) cmd_seq_i (
        .rst(rst), .mclk(mclk),
        .seq_we(seq_we), .seq_waddr(seq_waddr), .seq_wdata(seq_wdata),
        .seq_clr(seq_clr), .frame_sync(frame_sync), .cseq_ackn(cseq_ackn),
        .cseq_wr_en(cseq_wr_en), .cseq_waddr(cseq_waddr), .cseq_wdata(cseq_wdata)
    );

    cmd_mux cmd_mux_i (
        .rst(rst), .mclk(mclk),
        .fifo_nempty(fifo_nempty), .fifo_addr(fifo_addr), .fifo_data(fifo_data),
        .cseq_wr_en(cseq_wr_en), .cseq_waddr(cseq_waddr), .cseq_wdata(cseq_wdata),
        .fifo_re(fifo_re), .cseq_ackn(cseq_ackn),
        .par_waddr(par_waddr), .par_data(par_data),
        .byte_ad(byte_ad), .ad_stb(ad_stb)
    );

    // slave sees only the byte stream, never the parallel bus
    byte_slave #(.slave_base(slave_base)) byte_slave_i (
        .rst(rst), .mclk(mclk),
        .ad_stb(ad_stb), .byte_ad(byte_ad),
        .rd_addr(rd_addr), .rd_data(rd_data), .wr_done(wr_done)
    );

endmodule

// File: test/cmd_checker.sv
`timescale 1ns/10ps

module cmd_checker #(
    parameter int         fifo_depth = 4,
    parameter int         seq_depth  = 8,
    parameter logic [4:0] slave_base = 5'h10
) (
    input logic        rst,          // clock
    input logic        mclk,         // async reset
    input logic [12:0] pre_waddr,
    input logic        start_wburst,
    input logic [12:0] waddr,
    input logic        wr_en,
    input logic [31:0] wdata,
    input logic        busy,
    input logic        seq_we,
    input logic [12:0] seq_waddr,
    input logic [31:0] seq_wdata,
    input logic        seq_clr,
    input logic        fifo_re,      // pop timing only
    input logic        fifo_nempty,
    input logic        cseq_ackn,    // acceptance timing only
    input logic [12:0] par_waddr,
    input logic [31:0] par_data,
    input logic [7:0]  byte_ad,
    input logic        ad_stb,
    input logic [3:0]  rd_addr,
    input logic [31:0] rd_data,
    input logic        wr_done
);
    int errors = 0; // read by the testbench
    int cyc;        // cycle number since reset
    logic [12:0] hq_a [64]; // accepted host writes, in order
    logic [31:0] hq_d [64];
    logic [5:0]  hq_wp, hq_rp;
    logic [12:0] sq_a [64]; // sequencer commands taken by the mux
    logic [31:0] sq_d [64];
    int          sq_t [64]; // cycle in which each one was taken
    logic [5:0]  sq_wp, sq_rp;
    logic [12:0] st_a [8];  // sequencer store model
    logic [31:0] st_d [8];
    int          st_n, st_i, hcount, gap;
    logic        sel, sel_w, sel_now, exp_seq, exp_ok, seen, pend, ready_now;
    logic [12:0] exp_a, last_a, fin_a;
    logic [31:0] exp_d, last_d, fin_d, keep;
    logic [3:0]  len_now, prev_len, last_len, fin_len, left;
    logic [4:0]  fin_base;  // address[12:8] as the slave rebuilds it
    logic [47:0] exp_sr;    // bytes still to come on byte_ad
    logic [7:0]  done_sh, done_nxt; // wr_done due times with bit 0 for this cycle
    logic [31:0] m_regs [16];
    logic [15:0] m_val;     // model registers written so far

    assign sel_w   = (pre_waddr & cmd_pkg::ctrl_mask) == (cmd_pkg::ctrl_addr & cmd_pkg::ctrl_mask);
    assign sel_now = start_wburst ? sel_w : sel;

    always_comb begin
        exp_seq = (sq_wp != sq_rp) && (sq_t[sq_rp] < cyc - 1); // held before the start cycle
        exp_ok  = exp_seq || (hq_wp != hq_rp);
        exp_a   = exp_seq ? sq_a[sq_rp] : hq_a[hq_rp];
        exp_d   = exp_seq ? sq_d[sq_rp] : hq_d[hq_rp];
        len_now = cmd_pkg::len_table[exp_a[7:4]];
        // another command waiting besides the one strobed now
        ready_now = fifo_nempty || ((sq_wp - sq_rp) > ((ad_stb && exp_seq) ? 6'd1 : 6'd0));
        done_nxt = (done_sh >> 1) | (ad_stb ? (8'd1 << (len_now - 1)) : 8'd0);
        fin_a   = ad_stb ? exp_a : last_a;
        fin_d   = ad_stb ? exp_d : last_d;
        fin_len = ad_stb ? len_now : last_len;
        fin_base = (fin_len > 4'd1) ? fin_a[12:8] : 5'd0; // AH is not sent for length 1
        keep    = (fin_len > 4'd2) ? 32'((64'd1 << (8 * (fin_len - 2))) - 1) : 32'd0;
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cyc     <= 0;
            hq_wp   <= '0;
            hq_rp   <= '0;
            sq_wp   <= '0;
            sq_rp   <= '0;
            st_n    <= 0;
            st_i    <= 0;
            hcount  <= 0;
            sel     <= 1'b0;
            gap     <= 0;
            seen    <= 1'b0;
            pend    <= 1'b0;
            left    <= '0;
            done_sh <= '0;
            m_val   <= '0;
        end else begin
            cyc <= cyc + 1;
            if (start_wburst) sel <= sel_w;
            if (wr_en && sel) begin
                hq_a[hq_wp] <= waddr;
                hq_d[hq_wp] <= wdata;
                hq_wp <= hq_wp + 1'b1;
            end
            hcount <= hcount + int'(wr_en && sel) - int'(fifo_re);
            if (seq_clr) begin
                st_n <= 0;
            end else if (seq_we && st_n < seq_depth) begin
                st_a[st_n] <= seq_waddr;
                st_d[st_n] <= seq_wdata;
                st_n <= st_n + 1;
            end
            if (cseq_ackn) begin // replay walks the store in order
                sq_a[sq_wp] <= st_a[st_i];
                sq_d[sq_wp] <= st_d[st_i];
                sq_t[sq_wp] <= cyc;
                sq_wp <= sq_wp + 1'b1;
                st_i <= (st_i + 1 == st_n) ? 0 : st_i + 1;
            end
            if (ad_stb && exp_ok) begin
                if (exp_seq) sq_rp <= sq_rp + 1'b1;
                else         hq_rp <= hq_rp + 1'b1;
                last_a <= exp_a;
                last_d <= exp_d;
                last_len <= len_now;
                exp_sr <= {exp_d, 3'b000, exp_a} >> 8;
                left   <= len_now - 1'b1;
            end else if (left != 0) begin
                exp_sr <= exp_sr >> 8;
                left   <= left - 1'b1;
            end
            gap <= ad_stb ? 1 : gap + 1;
            if (ad_stb) begin
                prev_len <= len_now;
                seen <= 1'b1;
                pend <= (len_now == 4'd1) && ready_now;
            end else if (gap == int'(prev_len) - 1) begin
                pend <= ready_now; // previous stream ends in this cycle
            end
            done_sh <= done_nxt;
            if (done_nxt[0] && fin_base == slave_base) begin
                m_regs[fin_a[3:0]] <= fin_d & keep; // unsent data bytes read as zero
                m_val[fin_a[3:0]]  <= 1'b1;
            end
        end
    end

    a_src: assert property (@(posedge rst) disable iff (mclk) ad_stb |-> exp_ok)
        else begin
            errors++;
            $error("ad_stb without any accepted command pending");
        end
    a_par: assert property (@(posedge rst) disable iff (mclk)
        ad_stb && exp_ok |-> par_waddr == exp_a && par_data == exp_d)
        else begin
            errors++;
            $error("[FAIL] par_waddr/par_data %h/%h expected %h/%h", $sampled(par_waddr),
                   $sampled(par_data), $sampled(exp_a), $sampled(exp_d));
        end
    a_al: assert property (@(posedge rst) disable iff (mclk)
        ad_stb && exp_ok |-> byte_ad == exp_a[7:0])
        else begin
            errors++;
            $error("[FAIL] byte_ad %h expected %h (AL)", $sampled(byte_ad),
                   $sampled(exp_a[7:0]));
        end
    a_byte: assert property (@(posedge rst) disable iff (mclk)
        !ad_stb && left != 0 |-> byte_ad == exp_sr[7:0])
        else begin
            errors++;
            $error("[FAIL] byte_ad %h expected %h", $sampled(byte_ad),
                   $sampled(exp_sr[7:0]));
        end
    a_gap_min: assert property (@(posedge rst) disable iff (mclk)
        ad_stb && seen |-> gap >= int'(prev_len))
        else begin
            errors++;
            $error("ad_stb came before the previous byte stream ended");
        end
    a_gap_eq: assert property (@(posedge rst) disable iff (mclk)
        ad_stb && seen && pend |-> gap == int'(prev_len))
        else begin
            errors++;
            $error("[FAIL] ad_stb spacing %h expected %h", $sampled(gap),
                   $sampled(prev_len));
        end
    a_done: assert property (@(posedge rst) disable iff (mclk) wr_done == done_sh[0])
        else begin
            errors++;
            $error("[FAIL] wr_done %h expected %h", $sampled(wr_done),
                   $sampled(done_sh[0]));
        end
    a_reg: assert property (@(posedge rst) disable iff (mclk)
        m_val[rd_addr] |-> rd_data == m_regs[rd_addr])
        else begin
            errors++;
            $error("[FAIL] rd_data %h expected %h", $sampled(rd_data),
                   $sampled(m_regs[rd_addr]));
        end
    a_busy: assert property (@(posedge rst) disable iff (mclk)
        busy == ((hcount >= fifo_depth / 2) && sel_now))
        else begin
            errors++;
            $error("[FAIL] busy %h expected %h", $sampled(busy),
                   $sampled((hcount >= fifo_depth / 2) && sel_now));
        end
    a_lost: assert property (@(posedge rst) disable iff (mclk)
        wr_en && sel |-> hcount < fifo_depth)
        else begin
            errors++;
            $error("selected host write hit a full FIFO and was lost");
        end

endmodule

// File: test/cmd_tb.sv
`timescale 1ns/10ps

module cmd_tb;
    logic        rst, mclk;   // clock, reset
    logic [12:0] pre_waddr, waddr, seq_waddr, par_waddr;
    logic [31:0] wdata, seq_wdata, par_data, rd_data;
    logic        start_wburst, wr_en, busy, seq_we, seq_clr, frame_sync;
    logic [7:0]  byte_ad;
    logic        ad_stb, wr_done;
    logic [3:0]  rd_addr;
    logic [31:0] lfsr = 32'h3dee;
    int cycles, expected_done, done_seen, passed, failed, err_before;

    cmd_top #(.fifo_depth(4), .seq_depth(8), .slave_base(5'h10)) dut_i (.*);

    bind cmd_top cmd_checker #(.fifo_depth(fifo_depth), .seq_depth(seq_depth),
                               .slave_base(slave_base)) chk_i (.*);

    initial begin
        rst = 1'b0;
        forever #10 rst = ~rst;
    end

    always @(posedge rst) begin
        cycles++;
        if (wr_done) done_seen++; // every command ends with wr_done
        if (cycles == 4000) begin
            $display("timeout: commands still outstanding after 4000 cycles");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // addresses step the length code and register index together
    task automatic host_burst(input logic [12:0] pre, input logic [3:0] code,
                              input logic [3:0] idx, input int n, input bit counted);
        @(negedge rst);
        start_wburst = 1'b1;
        pre_waddr    = pre;
        @(negedge rst);
        start_wburst = 1'b0;
        for (int k = 0; k < n; k++) begin
            while (busy) @(negedge rst); // host obeys back-pressure
            wr_en = 1'b1;
            waddr = {pre[12:8], 4'(code + k), 4'(idx + k)};
            wdata = rand_bits(32);
            @(negedge rst);
            wr_en = 1'b0;
        end
        if (counted) expected_done += n;
    endtask

    task automatic seq_add(input logic [12:0] a);
        @(negedge rst);
        seq_we    = 1'b1;
        seq_waddr = a;
        seq_wdata = rand_bits(32);
        @(negedge rst);
        seq_we = 1'b0;
    endtask

    task automatic frame(input int n_cmds);
        @(negedge rst);
        frame_sync = 1'b1;
        @(negedge rst);
        frame_sync = 1'b0;
        expected_done += n_cmds;
    endtask

    task automatic finish_test(input int num, input string name);
        while (done_seen < expected_done) @(negedge rst);
        repeat (3) @(negedge rst); // let the last checks sample
        if (dut_i.chk_i.errors == err_before) passed++;
        else failed++;
        $display("test %0d %s: %s", num, name,
                 (dut_i.chk_i.errors == err_before) ? "ok" : "errors");
        err_before = dut_i.chk_i.errors;
    endtask

    initial begin
        mclk         = 1'b1;
        pre_waddr    = '0;
        start_wburst = 1'b0;
        waddr        = '0;
        wr_en        = 1'b0;
        wdata        = '0;
        seq_we       = 1'b0;
        seq_waddr    = '0;
        seq_wdata    = '0;
        seq_clr      = 1'b0;
        frame_sync   = 1'b0;
        rd_addr      = '0;
        repeat (10) @(negedge rst);
        mclk = 1'b0;

        host_burst(13'h1000, 4'd0, 4'd1, 1, 1'b1);
        host_burst(13'h0400, 4'd1, 4'd2, 2, 1'b0); // outside the control range
        finish_test(1, "host write range filter");

        host_burst(13'h1000, 4'd0, 4'd2, 6, 1'b1); // lengths 1 to 6
        finish_test(2, "ad_stb spacing");

        seq_add(13'h1028);
        seq_add(13'h1019);
        seq_add(13'h1159); // other slave base so register 9 keeps the value of 0x1019
        host_burst(13'h1000, 4'd3, 4'd4, 3, 1'b1);
        frame(3);
        finish_test(3, "sequencer priority");

        host_burst(13'h1000, 4'd14, 4'd11, 2, 1'b1); // long codes give 6 cycles
        frame(3); // replay of the same store
        for (int i = 0; i < 16; i++) begin
            @(negedge rst);
            rd_addr = 4'(i);
        end
        finish_test(4, "byte stream and register file");

        host_burst(13'h1000, 4'd5, 4'd0, 6, 1'b1); // FIFO fills up so busy must rise
        host_burst(13'h0000, 4'd5, 4'd6, 4, 1'b0);
        for (int i = 0; i < 16; i++) begin
            @(negedge rst);
            rd_addr = 4'(i);
        end
        finish_test(5, "busy back-pressure");

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && dut_i.chk_i.errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: list.f
common/cmd_pkg.sv
design/cmd_fifo.sv
design/cmd_seq.sv
cmd_mux/cmd_mux.sv
design/byte_slave.sv
design/cmd_top.sv
test/cmd_checker.sv
test/cmd_tb.sv
